/* src/bus_arbiter.sv */
module bus_arbiter
   import busint_pkg::*;
#(
   parameter int DMA_CREDITS  = 2,
   parameter int DRAM_LATENCY = 3
)
(
   input  logic        mclk,
   input  logic        reset,
   input  bus_addr_u   addr,
   input  logic [31:0] wdata,
   input  logic        req,
   input  logic        write,
   input  logic        dma_valid,
   input  logic [21:0] dma_addr,
   input  logic        dma_write,
   input  logic [31:0] dma_wdata,
   input  logic        mem_done,
   input  logic [31:0] mem_rdata,
   input  logic        io_ack,
   input  logic [31:0] io_rdata,
   output logic        mem_valid,
   output bus_addr_u   mem_addr,
   output logic        mem_write,
   output logic [31:0] mem_wdata,
   output logic        io_req,
   output logic [6:0]  io_addr_off,
   output logic        io_write,
   output logic [31:0] io_wdata,
   output logic        bus_timeout,
   output logic [31:0] rdata,
   output logic        ack,
   output logic        load,
   output bus_state_t  bus_state,
   output logic        dma_credit,
   output logic [31:0] dma_rdata,
   output logic        dma_rvalid
);

   localparam int CNT_W = $clog2(DMA_CREDITS + 1);
   localparam int PTR_W = (DMA_CREDITS > 1) ? $clog2(DMA_CREDITS) : 1;

   bus_state_t state;
   bus_state_t next_state;
   logic       dec_dram;
   logic       dec_io;
   logic       req_issued;
   logic [4:0] timeout_count;
   logic       timed_out;
   logic       cpu_done;
   logic       dma_done;

   // owner and direction of each command in the dram pipeline
   logic [DRAM_LATENCY-1:0] tag_dma;
   logic [DRAM_LATENCY-1:0] tag_read;

   // commands accepted from the dma master, not yet completed
   logic [CNT_W-1:0] dma_inflight;

   // queue of dma commands waiting for the bus
   logic [21:0]            fifo_addr [DMA_CREDITS];
   logic [DMA_CREDITS-1:0] fifo_write;
   logic [31:0]            fifo_wdata [DMA_CREDITS];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [CNT_W-1:0]       fifo_cnt;
   logic                   fifo_pop;

   assign dec_dram = addr.xbus.region < dram_limit;
   assign dec_io   = addr.unibus.page == io_page;

   always_comb
   begin
      next_state = state;
      case (state)
         bus_idle:
            // cpu has priority over a waiting dma master
            if (req)
               next_state = bus_req;
            else if (dma_valid || dma_inflight != '0)
               next_state = bus_slave;
         bus_req:
            if (ack)
               next_state = bus_wait;
         bus_wait:
            if (!req)
               next_state = bus_idle;
         bus_slave:
            if (dma_inflight == '0 && !dma_valid)
               next_state = bus_swait;
         bus_swait:
            next_state = bus_idle;
         default:
            next_state = bus_idle;
      endcase
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         state      <= bus_idle;
         req_issued <= 1'b0;
      end
      else
      begin
         state      <= next_state;
         req_issued <= state == bus_req;
      end
   end

   // saturating timeout, cleared once the cpu transfer has been acked
   always_ff @(posedge mclk)
   begin
      if (reset)
         timeout_count <= '0;
      else if (state == bus_wait)
         timeout_count <= '0;
      else if (state == bus_req && !timed_out)
         timeout_count <= timeout_count + 5'd1;
   end

   assign timed_out   = timeout_count == timeout_limit;
   assign bus_timeout = state == bus_req && timed_out;

   assign fifo_pop = state == bus_slave && fifo_cnt != '0;

   always_ff @(posedge mclk)
   begin
      if (dma_valid)
      begin
         fifo_addr[wr_ptr]  <= dma_addr;
         fifo_write[wr_ptr] <= dma_write;
         fifo_wdata[wr_ptr] <= dma_wdata;
      end
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         fifo_cnt     <= '0;
         dma_inflight <= '0;
      end
      else
      begin
         if (dma_valid)
            wr_ptr <= (wr_ptr == PTR_W'(DMA_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
         if (fifo_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DMA_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
         fifo_cnt     <= fifo_cnt + CNT_W'(dma_valid) - CNT_W'(fifo_pop);
         dma_inflight <= dma_inflight + CNT_W'(dma_valid) - CNT_W'(dma_credit);
      end
   end

   // dram port is shared: queue head in bus_slave, cpu otherwise
   always_comb
   begin
      if (state == bus_slave)
      begin
         mem_valid = fifo_pop;
         mem_addr  = fifo_addr[rd_ptr];
         mem_write = fifo_write[rd_ptr];
         mem_wdata = fifo_wdata[rd_ptr];
      end
      else
      begin
         mem_valid = state == bus_req && dec_dram && !req_issued;
         mem_addr  = addr;
         mem_write = write;
         mem_wdata = wdata;
      end
   end

   // tags line up with mem_done, DRAM_LATENCY cycles after mem_valid
   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         tag_dma  <= '0;
         tag_read <= '0;
      end
      else
      begin
         tag_dma  <= (tag_dma << 1) | DRAM_LATENCY'(mem_valid && state == bus_slave);
         tag_read <= (tag_read << 1) | DRAM_LATENCY'(mem_valid && !mem_write);
      end
   end

   assign cpu_done = mem_done && !tag_dma[DRAM_LATENCY-1];
   assign dma_done = mem_done && tag_dma[DRAM_LATENCY-1];

   assign dma_credit = dma_done;
   assign dma_rvalid = dma_done && tag_read[DRAM_LATENCY-1];
   assign dma_rdata  = mem_rdata;

   assign io_req      = state == bus_req && dec_io && !req_issued;
   assign io_addr_off = addr.unibus.reg_off;
   assign io_write    = write;
   assign io_wdata    = wdata;

   assign ack  = state == bus_req && (cpu_done || io_ack || timed_out);
   assign load = ack && !write;

   // a timed-out read returns zero
   assign rdata = cpu_done ? mem_rdata :
                  io_ack   ? io_rdata  :
                             32'h0000_0000;

   assign bus_state = state;

endmodule

/* src/busint.sv */
module busint
   import busint_pkg::*;
#(
   parameter int DRAM_WORDS   = 1024,
   parameter int DRAM_LATENCY = 3,
   parameter int DMA_CREDITS  = 2
)
(
   input  logic        mclk,
   input  logic        reset,
   input  logic [21:0] addr,
   input  logic [31:0] wdata,
   input  logic        req,
   input  logic        write,
   input  logic        dma_valid,
   input  logic [21:0] dma_addr,
   input  logic        dma_write,
   input  logic [31:0] dma_wdata,
   output logic [31:0] rdata,
   output logic        ack,
   output logic        load,
   output logic        interrupt,
   output logic        promdisable,
   output bus_state_t  bus_state,
   output logic        dma_credit,
   output logic [31:0] dma_rdata,
   output logic        dma_rvalid
);

   // arbiter <-> dram port
   logic        mem_valid;
   bus_addr_u   mem_addr;
   logic        mem_write;
   logic [31:0] mem_wdata;
   logic        mem_done;
   logic [31:0] mem_rdata;

   // arbiter <-> unibus registers
   logic        io_req;
   logic [6:0]  io_addr_off;
   logic        io_write;
   logic [31:0] io_wdata;
   logic        io_ack;
   logic [31:0] io_rdata;
   logic        bus_timeout;

   bus_arbiter #(
      .DMA_CREDITS  (DMA_CREDITS),
      .DRAM_LATENCY (DRAM_LATENCY)
   ) i_bus_arbiter (
      .mclk        (mclk),
      .reset       (reset),
      .addr        (addr),
      .wdata       (wdata),
      .req         (req),
      .write       (write),
      .dma_valid   (dma_valid),
      .dma_addr    (dma_addr),
      .dma_write   (dma_write),
      .dma_wdata   (dma_wdata),
      .mem_done    (mem_done),
      .mem_rdata   (mem_rdata),
      .io_ack      (io_ack),
      .io_rdata    (io_rdata),
      .mem_valid   (mem_valid),
      .mem_addr    (mem_addr),
      .mem_write   (mem_write),
      .mem_wdata   (mem_wdata),
      .io_req      (io_req),
      .io_addr_off (io_addr_off),
      .io_write    (io_write),
      .io_wdata    (io_wdata),
      .bus_timeout (bus_timeout),
      .rdata       (rdata),
      .ack         (ack),
      .load        (load),
      .bus_state   (bus_state),
      .dma_credit  (dma_credit),
      .dma_rdata   (dma_rdata),
      .dma_rvalid  (dma_rvalid)
   );

   dram_port #(
      .DRAM_WORDS   (DRAM_WORDS),
      .DRAM_LATENCY (DRAM_LATENCY)
   ) i_dram_port (
      .mclk      (mclk),
      .reset     (reset),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_write (mem_write),
      .mem_wdata (mem_wdata),
      .mem_done  (mem_done),
      .mem_rdata (mem_rdata)
   );

   // the cpu address is still on the bus when the timeout fires
   io_regs i_io_regs (
      .mclk         (mclk),
      .reset        (reset),
      .io_req       (io_req),
      .io_addr_off  (io_addr_off),
      .io_write     (io_write),
      .io_wdata     (io_wdata),
      .bus_timeout  (bus_timeout),
      .timeout_addr (addr),
      .io_ack       (io_ack),
      .io_rdata     (io_rdata),
      .interrupt    (interrupt),
      .promdisable  (promdisable)
   );

endmodule

/* src/busint_pkg.sv */
package busint_pkg;

   // 22-bit bus address, decoded either as xbus region/offset or unibus page/register
   typedef union packed
   {
      struct packed
      {
         logic [3:0]  region;
         logic [17:0] offset;
      } xbus;
      struct packed
      {
         logic [14:0] page;
         logic [6:0]  reg_off;
      } unibus;
   } bus_addr_u;

   // one-hot bus states, idle is all zeros
   typedef logic [3:0] bus_state_t;

   localparam bus_state_t bus_idle  = 4'b0000;
   localparam bus_state_t bus_req   = 4'b0001;
   localparam bus_state_t bus_wait  = 4'b0010;
   localparam bus_state_t bus_slave = 4'b0100;
   localparam bus_state_t bus_swait = 4'b1000;

   // region tags below this one are dram (addresses below 17000000 octal)
   localparam logic [3:0] dram_limit = 4'o17;

   // unibus page holding 17766000-17766177 octal
   localparam logic [14:0] io_page = 15'(22'o17766000 >> 7);

   // register offsets within the unibus page
   localparam logic [6:0] mode_reg_off   = 7'o12;
   localparam logic [6:0] int_status_off = 7'o40;
   localparam logic [6:0] err_status_off = 7'o44;

   // bus_req cycles before a transfer with no responder is ended
   localparam logic [4:0] timeout_limit = 5'd31;

endpackage

/* src/dram_port.sv */
module dram_port
   import busint_pkg::*;
#(
   parameter int DRAM_WORDS   = 1024,
   parameter int DRAM_LATENCY = 3
)
(
   input  logic        mclk,
   input  logic        reset,
   input  logic        mem_valid,
   input  bus_addr_u   mem_addr,
   input  logic        mem_write,
   input  logic [31:0] mem_wdata,
   output logic        mem_done,
   output logic [31:0] mem_rdata
);

   localparam int IDX_W = (DRAM_WORDS > 1) ? $clog2(DRAM_WORDS) : 1;

   logic [31:0]             mem [DRAM_WORDS];
   logic [IDX_W-1:0]        word_idx;
   logic [DRAM_LATENCY-1:0] done_pipe;
   logic [31:0]             data_pipe [DRAM_LATENCY];

   // addresses wrap onto the array
   assign word_idx = IDX_W'(mem_addr % DRAM_WORDS);

   // writes land in the array as soon as they are accepted
   always_ff @(posedge mclk)
   begin
      if (mem_valid && mem_write)
         mem[word_idx] <= mem_wdata;
   end

   // read data is taken at acceptance and then just travels down the pipe
   always_ff @(posedge mclk)
   begin
      data_pipe[0] <= mem[word_idx];
      for (int i = 1; i < DRAM_LATENCY; i++)
      begin
         data_pipe[i] <= data_pipe[i-1];
      end
   end

   // one completion per accepted command, reads and writes alike
   always_ff @(posedge mclk)
   begin
      if (reset)
         done_pipe <= '0;
      else
         done_pipe <= (done_pipe << 1) | DRAM_LATENCY'(mem_valid);
   end

   assign mem_done  = done_pipe[DRAM_LATENCY-1];
   assign mem_rdata = data_pipe[DRAM_LATENCY-1];

endmodule

/* src/io_regs.sv */
module io_regs
   import busint_pkg::*;
(
   input  logic        mclk,
   input  logic        reset,
   input  logic        io_req,
   input  logic [6:0]  io_addr_off,
   input  logic        io_write,
   input  logic [31:0] io_wdata,
   input  logic        bus_timeout,
   input  bus_addr_u   timeout_addr,
   output logic        io_ack,
   output logic [31:0] io_rdata,
   output logic        interrupt,
   output logic        promdisable
);

   logic [15:0] mode_reg;
   logic        int_pending;
   logic [15:0] err_status;
   logic        wr_mode;
   logic        wr_int;
   logic [31:0] rd_word;

   assign wr_mode = io_req && io_write && io_addr_off == mode_reg_off;
   assign wr_int  = io_req && io_write && io_addr_off == int_status_off;

   // mode register: bit 0 disables the prom, bit 1 enables the interrupt
   always_ff @(posedge mclk)
   begin
      if (reset)
         mode_reg <= '0;
      else if (wr_mode)
         mode_reg <= io_wdata[15:0];
   end

   // a new timeout wins over a clear in the same cycle
   always_ff @(posedge mclk)
   begin
      if (reset)
         int_pending <= 1'b0;
      else if (bus_timeout)
         int_pending <= 1'b1;
      else if (wr_int)
         int_pending <= 1'b0;
   end

   // low half of the address that timed out
   always_ff @(posedge mclk)
   begin
      if (reset)
         err_status <= '0;
      else if (bus_timeout)
         err_status <= timeout_addr.xbus.offset[15:0];
   end

   always_comb
   begin
      case (io_addr_off)
         mode_reg_off:   rd_word = {16'h0000, mode_reg};
         int_status_off: rd_word = {31'h0000_0000, int_pending};
         err_status_off: rd_word = {16'h0000, err_status};
         default:        rd_word = 32'h0000_0000;
      endcase
   end

   // single-cycle register access
   always_ff @(posedge mclk)
   begin
      if (reset)
         io_ack <= 1'b0;
      else
         io_ack <= io_req;
   end

   always_ff @(posedge mclk)
   begin
      if (io_req)
         io_rdata <= rd_word;
   end

   assign promdisable = mode_reg[0];
   assign interrupt   = int_pending & mode_reg[1];

endmodule

/* tb.f */
src/busint_pkg.sv
src/dram_port.sv
src/io_regs.sv
src/bus_arbiter.sv
src/busint.sv
tb/busint_assertions.sv
tb/tb_busint.sv

/* tb/busint_assertions.sv */
module busint_assertions
#(
   parameter int DMA_CREDITS = 2
)
(
   input logic                               mclk,
   input logic                               reset,
   input logic                               ack,
   input logic                               mem_valid,
   input logic                               io_req,
   input logic [$clog2(DMA_CREDITS + 1)-1:0] dma_inflight
);

   // cpu acknowledge is a single-cycle pulse
   ack_one_cycle: assert property (@(posedge mclk) disable iff (reset) ack |=> !ack)
      else $error("ack high for more than one cycle");

   // dram and unibus registers are never addressed together
   no_req_overlap: assert property (@(posedge mclk) disable iff (reset) !(mem_valid && io_req))
      else $error("mem_valid and io_req asserted together");

   // dma master never gets ahead of its credits
   inflight_bound: assert property (@(posedge mclk) disable iff (reset)
                                    dma_inflight <= DMA_CREDITS)
      else $error("in-flight dma count above credit limit");

endmodule

bind bus_arbiter busint_assertions #(
   .DMA_CREDITS (DMA_CREDITS)
) i_busint_assertions (
   .mclk         (mclk),
   .reset        (reset),
   .ack          (ack),
   .mem_valid    (mem_valid),
   .io_req       (io_req),
   .dma_inflight (dma_inflight)
);

/* tb/tb_busint.sv */
module tb_busint
   import busint_pkg::*;
();

   localparam int DRAM_WORDS   = 1024;
   localparam int DRAM_LATENCY = 3;
   localparam int DMA_CREDITS  = 2;

   localparam int          burst_len     = 8;
   localparam logic [21:0] io_base       = 22'o17766000;
   localparam logic [21:0] unmapped_addr = 22'o17123456;

   logic        mclk;
   logic        reset;
   logic [21:0] addr;
   logic [31:0] wdata;
   logic        req;
   logic        write;
   logic        dma_valid;
   logic [21:0] dma_addr;
   logic        dma_write;
   logic [31:0] dma_wdata;
   logic [31:0] rdata;
   logic        ack;
   logic        load;
   logic        interrupt;
   logic        promdisable;
   bus_state_t  bus_state;
   logic        dma_credit;
   logic [31:0] dma_rdata;
   logic        dma_rvalid;

   int          mismatches;
   int          failures;
   int          credit_pulses;
   int          dma_issued;
   logic        ack_last;
   logic        table_done;
   logic [15:0] lfsr;
   logic [21:0] burst_first_addr;
   time         last_credit_time;

   // reference model of dram contents, mode register and pending timeout flag
   logic [31:0] shadow [DRAM_WORDS];
   logic [15:0] mode_m;
   logic        int_m;

   // transfer table
   string       t_name  [$];
   logic [21:0] t_addr  [$];
   logic        t_write [$];
   logic [31:0] t_data  [$];
   logic [31:0] t_exp   [$];

   busint #(
      .DRAM_WORDS   (DRAM_WORDS),
      .DRAM_LATENCY (DRAM_LATENCY),
      .DMA_CREDITS  (DMA_CREDITS)
   ) i_busint (
      .mclk        (mclk),
      .reset       (reset),
      .addr        (addr),
      .wdata       (wdata),
      .req         (req),
      .write       (write),
      .dma_valid   (dma_valid),
      .dma_addr    (dma_addr),
      .dma_write   (dma_write),
      .dma_wdata   (dma_wdata),
      .rdata       (rdata),
      .ack         (ack),
      .load        (load),
      .interrupt   (interrupt),
      .promdisable (promdisable),
      .bus_state   (bus_state),
      .dma_credit  (dma_credit),
      .dma_rdata   (dma_rdata),
      .dma_rvalid  (dma_rvalid)
   );

   initial
   begin
      mclk = 1'b0;
      forever #2 mclk = ~mclk;
   end

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] lfsr_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic bit is_dram(input logic [21:0] a);
      return a < 22'o17000000;
   endfunction

   function automatic bit is_io(input logic [21:0] a);
      return a >= 22'o17766000 && a <= 22'o17766177;
   endfunction

   function automatic int dram_index(input logic [21:0] a);
      return int'(a) % DRAM_WORDS;
   endfunction

   // edges from the one that raises req up to the one that sees ack
   function automatic int ack_cycles(input logic [21:0] a);
      if (is_dram(a))
         return DRAM_LATENCY + 2;
      else if (is_io(a))
         return 3;
      return int'(timeout_limit) + 2;
   endfunction

   function automatic void update_model(input logic [21:0] a, input logic w,
                                        input logic [31:0] d);
      if (is_dram(a))
      begin
         if (w)
            shadow[dram_index(a)] = d;
      end
      else if (is_io(a))
      begin
         if (w && a[6:0] == mode_reg_off)
            mode_m = d[15:0];
         if (w && a[6:0] == int_status_off)
            int_m = 1'b0;
      end
      else
         int_m = 1'b1;
   endfunction

   function automatic void add_entry(input string name, input logic [21:0] a, input logic w,
                                     input logic [31:0] d, input logic [31:0] e);
      t_name.push_back(name);
      t_addr.push_back(a);
      t_write.push_back(w);
      t_data.push_back(d);
      t_exp.push_back(e);
   endfunction

   function automatic void build_table();
      add_entry("dram write low",   22'o00001234, 1'b1, 32'hcafe_0001, 32'h0);
      add_entry("dram write high",  22'o16777777, 1'b1, 32'h5a5a_1234, 32'h0);
      add_entry("dram read low",    22'o00001234, 1'b0, 32'h0, 32'hcafe_0001);
      add_entry("dram read alias",  22'o00001234 + 22'(DRAM_WORDS), 1'b0, 32'h0,
                32'hcafe_0001);
      add_entry("dram read high",   22'o16777777, 1'b0, 32'h0, 32'h5a5a_1234);
      add_entry("mode write",       io_base | 22'(mode_reg_off), 1'b1, 32'h1, 32'h0);
      add_entry("mode read",        io_base | 22'(mode_reg_off), 1'b0, 32'h0, 32'h1);
      add_entry("unmapped read",    unmapped_addr, 1'b0, 32'h0, 32'h0);
      add_entry("err status read",  io_base | 22'(err_status_off), 1'b0, 32'h0,
                {16'h0000, unmapped_addr[15:0]});
      add_entry("int status set",   io_base | 22'(int_status_off), 1'b0, 32'h0, 32'h1);
      add_entry("mode int enable",  io_base | 22'(mode_reg_off), 1'b1, 32'h3, 32'h0);
      add_entry("mode read back",   io_base | 22'(mode_reg_off), 1'b0, 32'h0, 32'h3);
      add_entry("int status clear", io_base | 22'(int_status_off), 1'b1, 32'hffff_ffff, 32'h0);
      add_entry("int status read",  io_base | 22'(int_status_off), 1'b0, 32'h0, 32'h0);
      add_entry("unused reg read",  io_base | 22'o100, 1'b0, 32'h0, 32'h0);
   endfunction

   // holds req until ack and drops it on the same edge
   task automatic cpu_transfer(input logic [21:0] a, input logic w, input logic [31:0] d,
                               output logic [31:0] rd, output logic ld, output int cycles);
      cycles = 0;
      @(posedge mclk);
      addr  <= a;
      write <= w;
      wdata <= d;
      req   <= 1'b1;
      do
      begin
         @(posedge mclk);
         cycles++;
      end
      while (ack !== 1'b1);
      rd = rdata;
      ld = load;
      req <= 1'b0;
   endtask

   // writes random dram words at full credit rate and optionally reads them back
   task automatic dma_burst(input int n_wr, input bit with_reads);
      logic [21:0] a_list [$];
      logic [31:0] exp_q  [$];
      logic [21:0] a;
      logic [31:0] d;
      logic [31:0] e;
      logic        w;
      int          total;
      int          issued;
      int          returned;
      int          credits;
      for (int i = 0; i < n_wr; i++)
         a_list.push_back(22'(lfsr_bits(20)));
      burst_first_addr = a_list[0];
      total    = with_reads ? 2 * n_wr : n_wr;
      issued   = 0;
      returned = 0;
      credits  = DMA_CREDITS;
      while (returned < total)
      begin
         @(posedge mclk);
         if (dma_credit)
         begin
            credits++;
            returned++;
            last_credit_time = $time;
         end
         if (credits > DMA_CREDITS)
         begin
            $display("DMA credit returned with no command outstanding");
            failures++;
         end
         if (dma_rvalid)
         begin
            if (exp_q.size() == 0)
            begin
               $display("DMA read data returned with no read outstanding");
               failures++;
            end
            else
            begin
               e = exp_q.pop_front();
               if (dma_rdata !== e)
               begin
                  $display("Mismatch dma read: expected %h, actual %h", e, dma_rdata);
                  mismatches++;
               end
            end
         end
         if (issued < total && credits > 0)
         begin
            w = issued < n_wr;
            a = a_list[issued % n_wr];
            d = w ? lfsr_bits(32) : 32'h0;
            if (w)
               shadow[dram_index(a)] = d;
            else
               exp_q.push_back(shadow[dram_index(a)]);
            dma_valid <= 1'b1;
            dma_addr  <= a;
            dma_write <= w;
            dma_wdata <= d;
            credits--;
            issued++;
            dma_issued++;
         end
         else
            dma_valid <= 1'b0;
      end
      dma_valid <= 1'b0;
      if (exp_q.size() != 0)
      begin
         $display("DMA burst ended with %0d reads never returned", exp_q.size());
         failures++;
      end
   endtask

   task automatic print_counts();
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
   endtask

   // protocol monitor on pre-edge values
   always @(posedge mclk)
   begin
      if (!reset)
      begin
         if (ack && ack_last)
         begin
            $display("ack stayed high for more than one cycle");
            failures++;
         end
         if (i_busint.mem_valid && i_busint.io_req)
         begin
            $display("dram and register requests issued in the same cycle");
            failures++;
         end
         if (i_busint.i_bus_arbiter.dma_inflight > DMA_CREDITS)
         begin
            $display("more DMA commands in flight than credits allow");
            failures++;
         end
         if (dma_credit)
            credit_pulses++;
      end
      ack_last = ack;
   end

   initial
   begin
      int lim;
      wait (table_done);
      lim = t_name.size() * (int'(timeout_limit) + 10) + 3 * burst_len * 10;
      repeat (lim) @(posedge mclk);
      $display("Watchdog expired after %0d cycles, run stopped", lim);
      failures++;
      print_counts();
      $display("Done: errors found");
      $finish;
   end

   initial
   begin
      logic [31:0] rd;
      logic        ld;
      int          cycles;
      time         ack_time;
      reset            = 1'b1;
      addr             = '0;
      wdata            = '0;
      req              = 1'b0;
      write            = 1'b0;
      dma_valid        = 1'b0;
      dma_addr         = '0;
      dma_write        = 1'b0;
      dma_wdata        = '0;
      mismatches       = 0;
      failures         = 0;
      credit_pulses    = 0;
      dma_issued       = 0;
      ack_last         = 1'b0;
      lfsr             = 16'd64656;
      mode_m           = '0;
      int_m            = 1'b0;
      burst_first_addr = '0;
      last_credit_time = 0;
      build_table();
      table_done = 1'b1;

      repeat (10) @(posedge mclk);
      reset <= 1'b0;
      @(posedge mclk);
      if (bus_state !== bus_idle || ack !== 1'b0 || load !== 1'b0 || dma_credit !== 1'b0 ||
          dma_rvalid !== 1'b0 || interrupt !== 1'b0 || promdisable !== 1'b0)
      begin
         $display("outputs not at their reset values after reset");
         failures++;
      end

      for (int i = 0; i < t_name.size(); i++)
      begin
         cpu_transfer(t_addr[i], t_write[i], t_data[i], rd, ld, cycles);
         if (!t_write[i] && rd !== t_exp[i])
         begin
            $display("Mismatch %s: expected %h, actual %h", t_name[i], t_exp[i], rd);
            mismatches++;
         end
         if (ld !== !t_write[i])
         begin
            $display("Mismatch %s load: expected %b, actual %b", t_name[i], !t_write[i], ld);
            mismatches++;
         end
         if (cycles != ack_cycles(t_addr[i]))
         begin
            $display("Mismatch %s ack cycles: expected %0d, actual %0d", t_name[i],
                     ack_cycles(t_addr[i]), cycles);
            mismatches++;
         end
         update_model(t_addr[i], t_write[i], t_data[i]);
         @(posedge mclk);
         // the cycle after ack is spent waiting for req to fall
         if (bus_state !== bus_wait)
         begin
            $display("Mismatch %s state after ack: expected %h, actual %h", t_name[i],
                     bus_wait, bus_state);
            mismatches++;
         end
         if (promdisable !== mode_m[0] || interrupt !== (int_m & mode_m[1]))
         begin
            $display("Mismatch %s flags: expected %b%b, actual %b%b", t_name[i], mode_m[0],
                     int_m & mode_m[1], promdisable, interrupt);
            mismatches++;
         end
      end

      dma_burst(burst_len, 1'b1);

      // cpu read queued behind a dma write burst
      fork
         dma_burst(burst_len, 1'b0);
         begin
            repeat (3) @(posedge mclk);
            cpu_transfer(burst_first_addr, 1'b0, 32'h0, rd, ld, cycles);
            ack_time = $time;
         end
      join
      if (rd !== shadow[dram_index(burst_first_addr)])
      begin
         $display("Mismatch cpu read after dma: expected %h, actual %h",
                  shadow[dram_index(burst_first_addr)], rd);
         mismatches++;
      end
      if (ack_time <= last_credit_time)
      begin
         $display("CPU read finished before the DMA burst had completed");
         failures++;
      end

      repeat (5) @(posedge mclk);
      if (credit_pulses != dma_issued)
      begin
         $display("Mismatch dma credits: expected %0d, actual %0d", dma_issued, credit_pulses);
         mismatches++;
      end
      print_counts();
      if (mismatches == 0 && failures == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
